/* l1d_config.svh */
`ifndef L1D_CONFIG_SVH
`define L1D_CONFIG_SVH

// Address map of the direct-mapped data cache.
`define L1D_ADDR_W      32
`define L1D_OFFSET_W    6
`define L1D_INDEX_W     6
`define L1D_TAG_W       20

// Data widths.
`define L1D_WORD_W      32
`define L1D_LINE_W      512

// Number of sets, one line per set.
`define L1D_SETS        64

`endif

/* l1d_types_pkg.sv */
`include "l1d_config.svh"

package l1d_types_pkg;

        // Full byte address from the CPU.
        typedef logic [`L1D_ADDR_W-1:0] addr_t;

        // Address fields.
        typedef logic [`L1D_TAG_W-1:0] tag_t;
        typedef logic [`L1D_INDEX_W-1:0] index_t;

        // Word within a line, offset bits 5 to 2.
        typedef logic [`L1D_OFFSET_W-3:0] word_sel_t;

        // Data payloads.
        typedef logic [`L1D_WORD_W-1:0] word_t;
        typedef logic [`L1D_LINE_W-1:0] line_t;

endpackage

/* l1d_ctrl_pkg.sv */
package l1d_ctrl_pkg;

        // CPU request kind.
        typedef enum logic
        {
                op_load,
                op_store
        } cpu_op_e;

        // Controller states.
        typedef enum logic [1:0]
        {
                st_idle,
                st_lookup,
                st_miss_wait,
                st_replay
        } cache_state_e;

endpackage

/* l1d_array_if.sv */
`timescale 1ns/1ps

interface l1d_array_if
        import l1d_types_pkg::*;
();

        // Commands from the controller.
        index_t    index;
        word_sel_t word_sel;
        tag_t      req_tag;
        logic      refill;
        logic      update;
        line_t     refill_line;
        word_t     update_word;

        // Registered read results.
        logic      hit;
        word_t     rd_word;

        modport ctrl (
                output index, word_sel, req_tag, refill, update, refill_line, update_word,
                input  hit, rd_word
        );

        modport tag_arr (
                input  index, req_tag, refill,
                output hit
        );

        modport data_arr (
                input  index, word_sel, refill, update, refill_line, update_word,
                output rd_word
        );

endinterface

/* l1d_data_array.sv */
`timescale 1ns/1ps

`include "l1d_config.svh"

module l1d_data_array
        import l1d_types_pkg::*;
(
        input  logic          clk,
        input  logic          nrst,
        l1d_array_if.data_arr arr
);

        line_t lines [`L1D_SETS];

        // Refill takes the whole line; update patches a single word.
        always_ff @(posedge clk or negedge nrst)
        begin
                if (!nrst)
                begin
                        for (int i = 0; i < `L1D_SETS; i++)
                        begin
                                lines[i] <= '0;
                        end
                end
                else if (arr.refill)
                begin
                        lines[arr.index] <= arr.refill_line;
                end
                else if (arr.update)
                begin
                        lines[arr.index][arr.word_sel * `L1D_WORD_W +: `L1D_WORD_W] <=
                                arr.update_word;
                end
        end

        // Word read, registered every cycle from the current index.
        always_ff @(posedge clk or negedge nrst)
        begin
                if (!nrst)
                begin
                        arr.rd_word <= '0;
                end
                else
                begin
                        arr.rd_word <= lines[arr.index][arr.word_sel * `L1D_WORD_W +: `L1D_WORD_W];
                end
        end

endmodule

/* l1d_tag_array.sv */
`timescale 1ns/1ps

`include "l1d_config.svh"

module l1d_tag_array
        import l1d_types_pkg::*;
(
        input  logic         clk,
        input  logic         nrst,
        l1d_array_if.tag_arr arr
);

        logic [`L1D_SETS-1:0] valid;
        tag_t                 tags [`L1D_SETS];

        always_ff @(posedge clk or negedge nrst)
        begin
                if (!nrst)
                begin
                        valid <= '0;
                end
                else if (arr.refill)
                begin
                        valid[arr.index] <= 1'b1;
                end
        end

        always_ff @(posedge clk)
        begin
                if (arr.refill)
                begin
                        tags[arr.index] <= arr.req_tag;
                end
        end

        // Lookup result for the set addressed in the previous cycle.
        always_ff @(posedge clk or negedge nrst)
        begin
                if (!nrst)
                begin
                        arr.hit <= 1'b0;
                end
                else
                begin
                        arr.hit <= valid[arr.index] && (tags[arr.index] == arr.req_tag);
                end
        end

endmodule

/* l1d_ctrl.sv */
`timescale 1ns/1ps

`include "l1d_config.svh"

module l1d_ctrl
        import l1d_types_pkg::*;
        import l1d_ctrl_pkg::*;
(
        input  logic      clk,
        input  logic      nrst,
        input  logic      cpu_req,
        input  cpu_op_e   cpu_op,
        input  addr_t     cpu_addr,
        input  word_t     cpu_wdata,
        input  logic      l2_valid,
        input  line_t     l2_line,
        output logic      stall,
        output logic      rd_valid,
        output word_t     rd_data,
        output logic      l2_req,
        output logic      l2_wr,
        output addr_t     l2_addr,
        output word_t     l2_wdata,
        l1d_array_if.ctrl arr
);

        cache_state_e state;
        addr_t        req_addr;
        cpu_op_e      req_op;
        word_t        req_wdata;
        logic         lookup_wait;
        logic         accept;
        logic         lookup_done;

        assign accept      = (state == st_idle) && cpu_req && !stall;
        assign lookup_done = (state == st_lookup) && !lookup_wait;

        // Array fields come from the latched request.
        assign arr.index       = req_addr[`L1D_OFFSET_W +: `L1D_INDEX_W];
        assign arr.word_sel    = req_addr[`L1D_OFFSET_W-1:2];
        assign arr.req_tag     = req_addr[`L1D_ADDR_W-1 -: `L1D_TAG_W];
        assign arr.refill      = (state == st_miss_wait) && l2_valid;
        assign arr.update      = lookup_done && (req_op == op_store) && arr.hit;
        assign arr.refill_line = l2_line;
        assign arr.update_word = req_wdata;

        // Load data straight from the registered word read.
        assign rd_data = arr.rd_word;

        // Line address for a refill, word address for a write-through.
        assign l2_addr  = (req_op == op_store) ?
                          {req_addr[`L1D_ADDR_W-1:2], 2'b00} :
                          {req_addr[`L1D_ADDR_W-1:`L1D_OFFSET_W], {`L1D_OFFSET_W{1'b0}}};
        assign l2_wdata = req_wdata;

        always_ff @(posedge clk or negedge nrst)
        begin
                if (!nrst)
                begin
                        state       <= st_idle;
                        req_addr    <= '0;
                        req_op      <= op_load;
                        req_wdata   <= '0;
                        lookup_wait <= 1'b0;
                        stall       <= 1'b0;
                        rd_valid    <= 1'b0;
                        l2_req      <= 1'b0;
                        l2_wr       <= 1'b0;
                end
                else
                begin
                        rd_valid <= 1'b0;
                        l2_req   <= 1'b0;
                        l2_wr    <= 1'b0;
                        case (state)
                        st_idle:
                        begin
                                if (accept)
                                begin
                                        req_addr    <= cpu_addr;
                                        req_op      <= cpu_op;
                                        req_wdata   <= cpu_wdata;
                                        lookup_wait <= 1'b1;
                                        stall       <= 1'b1;
                                        state       <= st_lookup;
                                end
                        end
                        st_lookup:
                        begin
                                // First cycle lets the arrays register the new index.
                                if (lookup_wait)
                                begin
                                        lookup_wait <= 1'b0;
                                end
                                else if (req_op == op_store)
                                begin
                                        l2_wr <= 1'b1;
                                        stall <= 1'b0;
                                        state <= st_idle;
                                end
                                else if (arr.hit)
                                begin
                                        rd_valid <= 1'b1;
                                        stall    <= 1'b0;
                                        state    <= st_idle;
                                end
                                else
                                begin
                                        l2_req <= 1'b1;
                                        state  <= st_miss_wait;
                                end
                        end
                        st_miss_wait:
                        begin
                                if (l2_valid)
                                begin
                                        state <= st_replay;
                                end
                        end
                        st_replay:
                        begin
                                // Refilled word is on rd_word from here on.
                                rd_valid <= 1'b1;
                                stall    <= 1'b0;
                                state    <= st_idle;
                        end
                        default:
                        begin
                                state <= st_idle;
                        end
                        endcase
                end
        end

endmodule

/* l1d_top.sv */
`timescale 1ns/1ps

module l1d_top
        import l1d_types_pkg::*;
        import l1d_ctrl_pkg::*;
(
        input  logic    clk,
        input  logic    nrst,
        input  logic    cpu_req,
        input  cpu_op_e cpu_op,
        input  addr_t   cpu_addr,
        input  word_t   cpu_wdata,
        input  logic    l2_valid,
        input  line_t   l2_line,
        output logic    stall,
        output logic    rd_valid,
        output word_t   rd_data,
        output logic    l2_req,
        output logic    l2_wr,
        output addr_t   l2_addr,
        output word_t   l2_wdata
);

        l1d_array_if arr_if ();

        l1d_ctrl u_ctrl (
                .clk       (clk),
                .nrst      (nrst),
                .cpu_req   (cpu_req),
                .cpu_op    (cpu_op),
                .cpu_addr  (cpu_addr),
                .cpu_wdata (cpu_wdata),
                .l2_valid  (l2_valid),
                .l2_line   (l2_line),
                .stall     (stall),
                .rd_valid  (rd_valid),
                .rd_data   (rd_data),
                .l2_req    (l2_req),
                .l2_wr     (l2_wr),
                .l2_addr   (l2_addr),
                .l2_wdata  (l2_wdata),
                .arr       (arr_if)
        );

        l1d_tag_array u_tag_array (
                .clk  (clk),
                .nrst (nrst),
                .arr  (arr_if)
        );

        l1d_data_array u_data_array (
                .clk  (clk),
                .nrst (nrst),
                .arr  (arr_if)
        );

endmodule

/* l1d_checker.sv */
`timescale 1ns/1ps

module l1d_checker
        import l1d_types_pkg::*;
        import l1d_ctrl_pkg::*;
(
        input logic    clk,
        input logic    nrst,
        input logic    cpu_req,
        input cpu_op_e cpu_op,
        input addr_t   cpu_addr,
        input word_t   cpu_wdata,
        input logic    l2_valid,
        input line_t   l2_line,
        input logic    stall,
        input logic    rd_valid,
        input word_t   rd_data,
        input logic    l2_req,
        input logic    l2_wr,
        input addr_t   l2_addr,
        input word_t   l2_wdata
);

        logic    valid_tab [64];
        tag_t    tag_tab [64];
        word_t   shadow [4096];
        word_t   exp_q [$];
        logic    busy = 1'b0;
        logic    t_hit;
        logic    t_err;
        logic    t_req_seen;
        logic    t_fill_seen;
        logic    reset_checked = 1'b0;
        cpu_op_e t_op;
        addr_t   t_addr;
        word_t   t_wdata;
        word_t   t_exp;
        word_t   t_fill;
        int      cyc = 0;
        int      acc_cyc;
        int      fill_cyc;
        int      since;
        int      rec_num = 0;
        int      pass_count = 0;
        int      fail_count = 0;
        int      extra_errors = 0;

        // Default L2 contents, built from the byte address of each word.
        initial
        begin
                for (int i = 0; i < 4096; i++)
                begin
                        shadow[i] = {i[13:0], 2'b00, ~i[13:0], 2'b11};
                end
        end

        task automatic init_word(input addr_t a, input word_t d);
                shadow[a[13:2]] = d;
        endtask

        task automatic push_expected(input word_t e);
                exp_q.push_back(e);
        endtask

        task automatic flag_error();
                if (busy)
                        t_err = 1'b1;
                else
                        extra_errors++;
        endtask

        task automatic check_value(input string name, input word_t got, input word_t exp);
                if (got !== exp)
                begin
                        $display("FAIL test %0d: %s = 0x%08h, expected 0x%08h",
                                 rec_num, name, got, exp);
                        flag_error();
                end
        endtask

        task automatic problem(input string msg);
                $display("ERROR test %0d: %s", rec_num, msg);
                flag_error();
        endtask

        task automatic finish_test();
                if (t_err)
                        fail_count++;
                else
                        pass_count++;
                $display("test %0d: %s 0x%08h %s, %s", rec_num,
                         (t_op == op_store) ? "store" : "load ", t_addr,
                         t_hit ? "hit " : "miss", t_err ? "errors" : "ok");
                rec_num++;
                busy = 1'b0;
        endtask

        always @(posedge clk)
        begin
                if (!nrst)
                begin
                        for (int i = 0; i < 64; i++)
                        begin
                                valid_tab[i] = 1'b0;
                        end
                        busy = 1'b0;
                end
                else
                begin
                        cyc++;
                        if (!reset_checked)
                        begin
                                check_value("stall", stall, 0);
                                check_value("rd_valid", rd_valid, 0);
                                check_value("l2_req", l2_req, 0);
                                check_value("l2_wr", l2_wr, 0);
                                check_value("rd_data", rd_data, 0);
                                reset_checked = 1'b1;
                        end
                        if (busy)
                        begin
                                since = cyc - acc_cyc;
                                if (l2_req)
                                begin
                                        if (t_op != op_load || t_hit || since != 3)
                                                problem("line request where none was due");
                                        check_value("l2_addr", l2_addr, {t_addr[31:6], 6'b0});
                                        valid_tab[t_addr[11:6]] = 1'b1;
                                        tag_tab[t_addr[11:6]] = t_addr[31:12];
                                        t_req_seen = 1'b1;
                                end
                                // Refill edge; the answer must follow after one replay cycle.
                                if (l2_valid)
                                begin
                                        if (t_op != op_load || t_hit || !t_req_seen)
                                                problem("line returned where none was due");
                                        t_fill = l2_line[t_addr[5:2] * 32 +: 32];
                                        fill_cyc = cyc;
                                        t_fill_seen = 1'b1;
                                end
                                if (rd_valid)
                                begin
                                        if (t_op == op_store)
                                                problem("load data returned for a store");
                                        else if (t_hit && since != 3)
                                                problem("load hit data not at latency 2");
                                        else if (!t_hit && !t_req_seen)
                                                problem("miss answered without a line request");
                                        else if (!t_hit && (!t_fill_seen || cyc - fill_cyc != 2))
                                                problem("load miss data not one cycle after refill");
                                        check_value("rd_data", rd_data, shadow[t_addr[13:2]]);
                                        check_value("rd_data", rd_data, t_exp);
                                        if (!t_hit && t_fill_seen)
                                                check_value("rd_data", rd_data, t_fill);
                                        if (stall)
                                                problem("stall still high at load completion");
                                        finish_test();
                                end
                                else if (l2_wr)
                                begin
                                        if (t_op != op_store || since != 3)
                                                problem("write-through where none was due");
                                        check_value("l2_addr", l2_addr, {t_addr[31:2], 2'b0});
                                        check_value("l2_wdata", l2_wdata, t_wdata);
                                        shadow[t_addr[13:2]] = t_wdata;
                                        if (stall)
                                                problem("stall still high at store completion");
                                        finish_test();
                                end
                                else if (since >= 3 && (t_op == op_store || t_hit || !t_req_seen))
                                begin
                                        problem("no response at latency 2");
                                        finish_test();
                                end
                                else if (since >= 1 && !stall)
                                begin
                                        problem("stall low while a transaction is open");
                                end
                        end
                        else if (rd_valid || l2_req || l2_wr || stall)
                        begin
                                problem("DUT active without an accepted request");
                        end
                        // Acceptance follows the DUT rule, so requests under stall are skipped.
                        if (cpu_req && !stall)
                        begin
                                busy = 1'b1;
                                acc_cyc = cyc;
                                t_op = cpu_op;
                                t_addr = cpu_addr;
                                t_wdata = cpu_wdata;
                                t_hit = valid_tab[cpu_addr[11:6]] &&
                                        (tag_tab[cpu_addr[11:6]] == cpu_addr[31:12]);
                                t_err = 1'b0;
                                t_req_seen = 1'b0;
                                t_fill_seen = 1'b0;
                                if (exp_q.size() == 0)
                                begin
                                        problem("request accepted with no trace record left");
                                        t_exp = '0;
                                end
                                else
                                        t_exp = exp_q.pop_front();
                        end
                end
        end

endmodule

/* tb_l1d.sv */
`timescale 1ns/1ps

module tb_l1d;
        import l1d_types_pkg::*;
        import l1d_ctrl_pkg::*;

        logic    clk;
        logic    nrst;
        logic    cpu_req;
        cpu_op_e cpu_op;
        addr_t   cpu_addr;
        word_t   cpu_wdata;
        logic    l2_valid;
        line_t   l2_line;
        logic    stall;
        logic    rd_valid;
        word_t   rd_data;
        logic    l2_req;
        logic    l2_wr;
        addr_t   l2_addr;
        word_t   l2_wdata;

        logic [3:0] kinds [$];
        addr_t      addrs [$];
        word_t      datas [$];
        word_t      exps [$];
        word_t      mem [4096];
        logic       loaded = 1'b0;
        int         n_tests = 0;
        int         seed;

        l1d_top u_dut (.*);

        l1d_checker u_chk (.*);

        initial
        begin
                clk = 1'b0;
        end

        always #5 clk = ~clk;

        task automatic read_trace();
                int fd;
                int cnt;
                logic [3:0] k;
                addr_t a;
                word_t d;
                word_t e;
                logic [8*120-1:0] line_buf;
                fd = $fopen("l1d_trace.txt", "r");
                if (fd == 0)
                        $display("ERROR: cannot open l1d_trace.txt");
                while (fd != 0 && !$feof(fd))
                begin
                        line_buf = '0;
                        cnt = $fgets(line_buf, fd);
                        if (cnt > 0 && $sscanf(line_buf, "%h %h %h %h", k, a, d, e) == 4)
                        begin
                                kinds.push_back(k);
                                addrs.push_back(a);
                                datas.push_back(d);
                                exps.push_back(e);
                                if (k != 0)
                                        n_tests++;
                        end
                end
                if (fd != 0)
                        $fclose(fd);
        endtask

        // One request, plus a stray request held during stall that must be ignored.
        task automatic run_request(input logic [3:0] k, input addr_t a, input word_t d,
                                   input word_t e);
                u_chk.push_expected(e);
                @(posedge clk);
                #1;
                while (stall)
                begin
                        @(posedge clk);
                        #1;
                end
                cpu_req = 1'b1;
                cpu_op = (k == 2) ? op_store : op_load;
                cpu_addr = a;
                cpu_wdata = d;
                @(posedge clk);
                #1;
                cpu_addr = a ^ 32'h0000_2040;
                cpu_wdata = ~d;
                @(posedge clk);
                #1;
                cpu_req = 1'b0;
        endtask

        // L2 model answers a line request after 1 to 8 cycles.
        always
        begin
                @(posedge clk);
                if (nrst && l2_req)
                begin
                        addr_t la;
                        la = l2_addr;
                        repeat ($urandom % 8 + 1) @(posedge clk);
                        #1;
                        for (int w = 0; w < 16; w++)
                        begin
                                l2_line[w*32 +: 32] = mem[{la[13:6], w[3:0]}];
                        end
                        l2_valid = 1'b1;
                        @(posedge clk);
                        #1;
                        l2_valid = 1'b0;
                end
        end

        always @(posedge clk)
        begin
                if (nrst && l2_wr)
                        mem[l2_addr[13:2]] = l2_wdata;
        end

        initial
        begin
                wait (loaded);
                repeat (kinds.size() * 16 + 50) @(posedge clk);
                $display("ERROR: run timed out waiting for the DUT");
                $display("Simulation FAILED");
                $finish;
        end

        initial
        begin
                seed = $urandom(32'ha51c);
                nrst = 1'b0;
                cpu_req = 1'b0;
                cpu_op = op_load;
                cpu_addr = '0;
                cpu_wdata = '0;
                l2_valid = 1'b0;
                l2_line = '0;
                for (int i = 0; i < 4096; i++)
                begin
                        mem[i] = {i[13:0], 2'b00, ~i[13:0], 2'b11};
                end
                read_trace();
                loaded = 1'b1;
                repeat (5) @(posedge clk);
                #1;
                nrst = 1'b1;
                for (int i = 0; i < kinds.size(); i++)
                begin
                        if (kinds[i] == 0)
                        begin
                                mem[addrs[i][13:2]] = datas[i];
                                u_chk.init_word(addrs[i], datas[i]);
                        end
                end
                for (int i = 0; i < kinds.size(); i++)
                begin
                        if (kinds[i] != 0)
                                run_request(kinds[i], addrs[i], datas[i], exps[i]);
                end
                @(posedge clk);
                while (u_chk.busy)
                        @(posedge clk);
                repeat (2) @(posedge clk);
                $display("tests %0d, ok %0d, with errors %0d, other errors %0d",
                         n_tests, u_chk.pass_count, u_chk.fail_count, u_chk.extra_errors);
                if (n_tests > 0 && u_chk.fail_count == 0 && u_chk.extra_errors == 0 &&
                    u_chk.pass_count == n_tests)
                        $display("Simulation PASSED");
                else
                        $display("Simulation FAILED");
                $finish;
        end

endmodule

/* l1d_trace.txt */
# kind addr wdata expected
# kind 0 writes wdata into L2 memory, 1 is a load, 2 is a store
0 00000100 11112222 00000000
0 00001100 33334444 00000000
# First load to a set misses, then repeats hit
1 00000100 00000000 11112222
1 00000100 00000000 11112222
1 00000104 00000000 0104fefb
# Same index, other tag
1 00001100 00000000 33334444
1 00000100 00000000 11112222
# Store hit, then load back
2 00000108 deadbeef 00000000
1 00000108 00000000 deadbeef
# Store miss does not allocate
2 00002200 cafef00d 00000000
1 00002200 00000000 cafef00d
1 00002204 00000000 2204ddfb
1 00003ffc 00000000 3ffcc003
2 00001104 5a5a1234 00000000
1 00001104 00000000 5a5a1234
# Evicted line still holds the write-through data
1 00000108 00000000 deadbeef
1 00000000 00000000 0000ffff

/* vlog.f */
+incdir+.
l1d_types_pkg.sv
l1d_ctrl_pkg.sv
l1d_array_if.sv
l1d_data_array.sv
l1d_tag_array.sv
l1d_ctrl.sv
l1d_top.sv
l1d_checker.sv
tb_l1d.sv

/* Bender.yml */
package:
  name: l1d_cache

sources:
  - include_dirs:
      - .
    files:
      - l1d_types_pkg.sv
      - l1d_ctrl_pkg.sv
      - l1d_array_if.sv
      - l1d_data_array.sv
      - l1d_tag_array.sv
      - l1d_ctrl.sv
      - l1d_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - l1d_checker.sv
      - tb_l1d.sv
